/* all.f */
+incdir+logic
logic/pc_pkg.sv
logic/shift_reg.sv
logic/bit_counter.sv
logic/operand_serializer.sv
logic/pc_ctrl.sv
logic/rd_collector.sv
logic/pc_unit_top.sv
test/pc_unit_checker.sv
test/pc_unit_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal -f all.f --top-module pc_unit_tb -o pc_unit_sim
./obj_dir/pc_unit_sim | tee sim.log

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
   echo "Simulation failed"
   exit 1
fi
if ! grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then
   echo "Simulation ended without a result"
   exit 1
fi
echo "Simulation passed"

/* test/pc_unit_tb.sv */
module pc_unit_tb;

   typedef struct packed {
      logic [4:0]    ctrl;      // jump, jal_or_jalr, utype, pc_rel, trap
      pc_pkg::word_t imm;
      pc_pkg::word_t off;
      pc_pkg::word_t csr;
      logic [7:0]    delay;
      logic          extra_start;
   } row_t;

   localparam int ROWS = 9;

   logic          clk;
   logic          i_rst;
   logic          i_start;
   logic          i_jump;
   logic          i_jal_or_jalr;
   logic          i_utype;
   logic          i_pc_rel;
   logic          i_trap;
   pc_pkg::word_t i_imm_word;
   pc_pkg::word_t i_offset_word;
   pc_pkg::word_t i_csr_word;
   logic          i_ibus_ack;
   pc_pkg::word_t o_ibus_adr;
   logic          o_ibus_cyc;
   pc_pkg::word_t o_rd_word;
   logic          o_misaligned;
   logic          o_done;
   row_t          table_rows [ROWS];
   int            timeouts;

   pc_unit_top u_dut (.*);

   pc_unit_checker u_chk (.*);

   always #5 clk = ~clk;

   task automatic wait_cyc(input logic level, input string what);
      int n;
      n = 0;
      while (o_ibus_cyc !== level && n < 200) begin
         @(negedge clk);
         n++;
      end
      if (o_ibus_cyc !== level) begin
         $display("Timeout while waiting for o_ibus_cyc to %s", what);
         timeouts++;
      end
   endtask

   task automatic wait_done();
      int n;
      n = 0;
      while (o_done !== 1'b1 && n < 200) begin
         @(negedge clk);
         n++;
      end
      if (o_done !== 1'b1) begin
         $display("Timeout while waiting for o_done");
         timeouts++;
      end
   endtask

   // Holds the acknowledge off for a while, then pulses it for one cycle.
   task automatic acknowledge_fetch(input int delay, input logic extra_start);
      for (int i = 0; i < delay; i++) begin
         @(negedge clk);
         i_start = extra_start && (i == delay / 2);   // Must be ignored.
      end
      @(negedge clk);
      i_start    = 1'b0;
      i_ibus_ack = 1'b1;
      @(negedge clk);
      i_ibus_ack = 1'b0;
      wait_cyc(1'b0, "fall");
   endtask

   initial begin
      void'($urandom(3173));
      table_rows[0] = {5'b00000, 32'h0, 32'h0, 32'h0, 8'd0, 1'b0};
      table_rows[1] = {5'b11010, 32'h0, 32'h0000_0FF0, 32'h0, 8'd2, 1'b0};   // JAL
      table_rows[2] = {5'b11010, 32'h0, 32'h0000_0012, 32'h0, 8'd1, 1'b0};
      table_rows[3] = {5'b11000, 32'h0, 32'h0000_2003, 32'h0, 8'd0, 1'b0};   // JALR
      table_rows[4] = {5'b00100, 32'h1234_5ABC, 32'h0, 32'h0, 8'd3, 1'b0};   // LUI
      table_rows[5] = {5'b00110, 32'hFFFF_F123, 32'h0, 32'h0, 8'd0, 1'b0};   // AUIPC
      table_rows[6] = {5'b00001, 32'h0, 32'h0, 32'h0000_8005, 8'd1, 1'b0};   // Trap
      table_rows[7] = {5'b00000, 32'h0, 32'h0, 32'h0, 8'd40, 1'b1};
      table_rows[8] = {5'b11010, 32'h0, 32'hFFFF_FFF0, 32'h0, 8'd2, 1'b0};
      clk           = 1'b0;
      i_rst         = 1'b1;
      i_start       = 1'b0;
      {i_jump, i_jal_or_jalr, i_utype, i_pc_rel, i_trap} = '0;
      i_imm_word    = '0;
      i_offset_word = '0;
      i_csr_word    = '0;
      i_ibus_ack    = 1'b0;
      timeouts      = 0;
      repeat (3) @(negedge clk);
      i_rst = 1'b0;

      wait_cyc(1'b1, "rise after reset");
      acknowledge_fetch(5, 1'b0);
      $display("Reset fetch finished");

      for (int r = 0; r < ROWS; r++) begin
         @(negedge clk);
         {i_jump, i_jal_or_jalr, i_utype, i_pc_rel, i_trap} = table_rows[r].ctrl;
         i_imm_word    = table_rows[r].imm;
         i_offset_word = table_rows[r].off;
         i_csr_word    = table_rows[r].csr;
         i_start       = 1'b1;
         @(negedge clk);
         i_start = 1'b0;
         wait_done();
         acknowledge_fetch(table_rows[r].delay + ($urandom % 4), table_rows[r].extra_start);
      end
      repeat (5) @(negedge clk);

      $display("Tests: %0d, errors: %0d, timeouts: %0d",
               u_chk.test_count, u_chk.err_count, timeouts);
      if (u_chk.test_count != ROWS) begin
         $display("Only %0d of %0d operations completed", u_chk.test_count, ROWS);
      end
      if (timeouts == 0 && u_chk.err_count == 0 && u_chk.test_count == ROWS) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

/* test/pc_unit_checker.sv */
`include "pc_settings.svh"

module pc_unit_checker (
   input  logic          clk,
   input  logic          i_rst,
   input  logic          i_start,
   input  logic          i_jump,
   input  logic          i_jal_or_jalr,
   input  logic          i_utype,
   input  logic          i_pc_rel,
   input  logic          i_trap,
   input  pc_pkg::word_t i_imm_word,
   input  pc_pkg::word_t i_offset_word,
   input  pc_pkg::word_t i_csr_word,
   input  logic          i_ibus_ack,
   input  pc_pkg::word_t o_ibus_adr,
   input  logic          o_ibus_cyc,
   input  pc_pkg::word_t o_rd_word,
   input  logic          o_misaligned,
   input  logic          o_done
);

   pc_pkg::word_t pc_model;
   pc_pkg::word_t exp_pc;
   pc_pkg::word_t exp_rd;
   pc_pkg::word_t base;
   pc_pkg::word_t sum;
   logic          exp_mis;
   logic          busy;
   logic          ack_seen;
   logic          cyc_prev;
   int            cycles;
   int            test_count;
   int            err_count;
   int            test_errs;

   task automatic compare_word(input string name, input pc_pkg::word_t exp,
                               input pc_pkg::word_t act);
      if (exp !== act) begin
         $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
         err_count++;
         test_errs++;
      end
   endtask

   task automatic report_problem(input string what);
      $display("At %0t: %s", $time, what);
      err_count++;
      test_errs++;
   endtask

   //////////////////////////////////////////////////
   // Reference model, sampled on the rising edge
   //////////////////////////////////////////////////

   always @(posedge clk) begin
      if (i_rst) begin
         pc_model   = `PC_RESET_ADDR;
         busy       = 1'b0;
         ack_seen   = 1'b0;
         cyc_prev   = 1'b0;
         cycles     = 0;
         test_count = 0;
         err_count  = 0;
         test_errs  = 0;
      end else begin
         if (ack_seen && o_ibus_cyc) begin
            report_problem("o_ibus_cyc stayed high after the acknowledge");
         end
         if (cyc_prev && !o_ibus_cyc && !ack_seen) begin
            report_problem("o_ibus_cyc dropped before the acknowledge");
         end
         cyc_prev = o_ibus_cyc;
         ack_seen = o_ibus_cyc & i_ibus_ack;
         if (busy) begin
            cycles++;
         end
         if (o_done) begin
            if (!busy) begin
               report_problem("o_done pulsed without an accepted start");
            end else begin
               compare_word("done latency", 33, cycles);
               compare_word("o_rd_word", exp_rd, o_rd_word);
               compare_word("o_misaligned", exp_mis, o_misaligned);
               if (!o_ibus_cyc) begin
                  report_problem("o_ibus_cyc did not rise with o_done");
               end
               pc_model = exp_pc;
               busy     = 1'b0;
               test_count++;
               if (test_errs == 0) begin
                  $display("Test %0d finished: ok", test_count);
               end else begin
                  $display("Test %0d finished: %0d errors", test_count, test_errs);
               end
               test_errs = 0;
            end
         end
         if (o_ibus_cyc && !busy) begin
            compare_word("o_ibus_adr", pc_model, o_ibus_adr);   // Must hold under back-pressure.
         end
         if (i_start && !busy && !o_ibus_cyc) begin
            base    = i_pc_rel ? pc_model : '0;
            sum     = base + (i_utype ? (i_imm_word & 32'hFFFF_F000) : i_offset_word);
            exp_mis = sum[1];
            if (i_utype) begin
               exp_rd = sum;
            end else if (i_jal_or_jalr) begin
               exp_rd = pc_model + 32'd4;
            end else begin
               exp_rd = '0;
            end
            if (`PC_WITH_CSR && i_trap) begin
               exp_pc = i_csr_word & ~32'd1;
            end else if (i_jump) begin
               exp_pc = sum & ~32'd1;
            end else begin
               exp_pc = pc_model + 32'd4;
            end
            busy   = 1'b1;
            cycles = 0;
         end
      end
   end

endmodule

/* logic/pc_unit_top.sv */
module pc_unit_top (
   input  logic          clk,
   input  logic          i_rst,
   input  logic          i_start,
   input  logic          i_jump,
   input  logic          i_jal_or_jalr,
   input  logic          i_utype,
   input  logic          i_pc_rel,
   input  logic          i_trap,
   input  pc_pkg::word_t i_imm_word,
   input  pc_pkg::word_t i_offset_word,
   input  pc_pkg::word_t i_csr_word,
   input  logic          i_ibus_ack,
   output pc_pkg::word_t o_ibus_adr,
   output logic          o_ibus_cyc,
   output pc_pkg::word_t o_rd_word,
   output logic          o_misaligned,
   output logic          o_done
);

   logic             start_ok;
   logic             pc_en;
   pc_pkg::cnt_hi_t  cnt;
   pc_pkg::cnt_lsb_t cnt_r;
   logic             ser_imm;
   logic             ser_buf;
   logic             ser_csr_pc;
   logic             rd_bit;
   logic             bad_pc;

   bit_counter u_counter (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_start    (i_start),
      .i_ibus_cyc (o_ibus_cyc),
      .o_start_ok (start_ok),
      .o_pc_en    (pc_en),
      .o_cnt      (cnt),
      .o_cnt_r    (cnt_r),
      .o_cnt_done (),
      .o_done     (o_done)
   );

   operand_serializer u_serializer (
      .clk           (clk),
      .i_rst         (i_rst),
      .i_start_ok    (start_ok),
      .i_pc_en       (pc_en),
      .i_imm_word    (i_imm_word),
      .i_offset_word (i_offset_word),
      .i_csr_word    (i_csr_word),
      .o_imm         (ser_imm),
      .o_buf         (ser_buf),
      .o_csr_pc      (ser_csr_pc)
   );

   pc_ctrl u_pc_ctrl (
      .clk           (clk),
      .i_rst         (i_rst),
      .i_pc_en       (pc_en),
      .i_cnt         (cnt),
      .i_cnt_r       (cnt_r),
      .i_jump        (i_jump),
      .i_jal_or_jalr (i_jal_or_jalr),
      .i_utype       (i_utype),
      .i_pc_rel      (i_pc_rel),
      .i_trap        (i_trap),
      .i_imm         (ser_imm),
      .i_buf         (ser_buf),
      .i_csr_pc      (ser_csr_pc),
      .o_rd          (rd_bit),
      .o_bad_pc      (bad_pc),
      .o_ibus_adr    (o_ibus_adr),
      .o_ibus_cyc    (o_ibus_cyc),
      .i_ibus_ack    (i_ibus_ack)
   );

   rd_collector u_collector (
      .clk          (clk),
      .i_rst        (i_rst),
      .i_pc_en      (pc_en),
      .i_cnt        (cnt),
      .i_cnt_r      (cnt_r),
      .i_rd         (rd_bit),
      .i_bad_pc     (bad_pc),
      .o_rd_word    (o_rd_word),
      .o_misaligned (o_misaligned)
   );

endmodule

/* logic/rd_collector.sv */
module rd_collector (
   input  logic             clk,
   input  logic             i_rst,
   input  logic             i_pc_en,
   input  pc_pkg::cnt_hi_t  i_cnt,
   input  pc_pkg::cnt_lsb_t i_cnt_r,
   input  logic             i_rd,
   input  logic             i_bad_pc,
   output pc_pkg::word_t    o_rd_word,
   output logic            o_misaligned
);

   logic bit_time_1;

   assign bit_time_1 = i_pc_en & i_cnt_r[1] & (i_cnt == 3'd0);

   //////////////////////////////////////////////////
   // Deserializer
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_rd_word    <= '0;
         o_misaligned <= 1'b0;
      end else begin
         if (i_pc_en) begin
            o_rd_word <= {i_rd, o_rd_word[$bits(o_rd_word)-1:1]};   // LSB arrives first.
         end
         if (bit_time_1) begin
            o_misaligned <= i_bad_pc;                  // Bit 1 of the jump target.
         end
      end
   end

endmodule

/* logic/pc_ctrl.sv */
`include "pc_settings.svh"

module pc_ctrl #(
   parameter pc_pkg::word_t RESET_PC = `PC_RESET_ADDR
) (
   input  logic             clk,
   input  logic             i_rst,
   input  logic             i_pc_en,
   input  pc_pkg::cnt_hi_t  i_cnt,
   input  pc_pkg::cnt_lsb_t i_cnt_r,
   input  logic             i_jump,
   input  logic             i_jal_or_jalr,
   input  logic             i_utype,
   input  logic             i_pc_rel,
   input  logic             i_trap,
   input  logic             i_imm,
   input  logic             i_buf,
   input  logic             i_csr_pc,
   output logic             o_rd,
   output logic             o_bad_pc,
   output pc_pkg::word_t    o_ibus_adr,
   output logic             o_ibus_cyc,
   input  logic             i_ibus_ack
);

   localparam bit WITH_CSR = `PC_WITH_CSR;

   logic                      en_pc_r;
   logic                      pc;
   logic [`PC_WORD_BITS-1:1]  pc_par;
   logic                      new_pc;

   logic                      plus_4;
   logic                      pc_plus_4;
   logic                      pc_plus_4_cy;
   logic                      pc_plus_4_cy_r;

   logic                      offset_a;
   logic                      offset_b;
   logic                      imm_upper;
   logic                      pc_plus_offset;
   logic                      pc_plus_offset_cy;
   logic                      pc_plus_offset_cy_r;
   logic                      pc_plus_offset_aligned;

   // One bit of a serial adder, carry in the upper bit.
   function automatic logic [1:0] add_bit(input logic a, input logic b, input logic c);
      return {(a & b) | (c & (a ^ b)), a ^ b ^ c};
   endfunction

   shift_reg #(
      .LEN  (`PC_WORD_BITS),
      .INIT (RESET_PC)
   ) u_pc_reg (
      .clk   (clk),
      .i_rst (i_rst),
      .i_en  (i_pc_en),
      .i_d   (new_pc),
      .o_q   (pc),
      .o_par (pc_par)
   );

   assign o_ibus_adr = {pc_par, pc};

   //////////////////////////////////////////////////
   // Serial adders
   //////////////////////////////////////////////////

   assign plus_4 = i_cnt_r[2] & (i_cnt == 3'd0);                  // Bit time 2.
   assign {pc_plus_4_cy, pc_plus_4} = add_bit(pc, plus_4, pc_plus_4_cy_r);

   assign imm_upper = i_cnt[2] | (i_cnt[1:0] == 2'b11);           // Bit 12 and up.
   assign offset_a  = i_pc_rel & pc;
   assign offset_b  = i_utype ? (i_imm & imm_upper) : i_buf;
   assign {pc_plus_offset_cy, pc_plus_offset} =
      add_bit(offset_a, offset_b, pc_plus_offset_cy_r);

   // The flag is still clear at bit time 0, which drops target bit 0.
   assign pc_plus_offset_aligned = pc_plus_offset & en_pc_r;
   assign o_bad_pc = pc_plus_offset_aligned;

   always_comb begin
      if (WITH_CSR && i_trap) begin
         new_pc = i_csr_pc & en_pc_r;
      end else if (i_jump) begin
         new_pc = pc_plus_offset_aligned;
      end else begin
         new_pc = pc_plus_4;
      end
   end

   assign o_rd = (i_utype & pc_plus_offset_aligned) | (i_jal_or_jalr & pc_plus_4);

   assign o_ibus_cyc = en_pc_r & ~i_pc_en;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         en_pc_r             <= 1'b1;                             // Fetch from the reset address.
         pc_plus_4_cy_r      <= 1'b0;
         pc_plus_offset_cy_r <= 1'b0;
      end else begin
         pc_plus_4_cy_r      <= i_pc_en & pc_plus_4_cy;
         pc_plus_offset_cy_r <= i_pc_en & pc_plus_offset_cy;
         if (i_pc_en) begin
            en_pc_r <= 1'b1;
         end else if (o_ibus_cyc & i_ibus_ack) begin
            en_pc_r <= 1'b0;
         end
      end
   end

endmodule

/* logic/operand_serializer.sv */
module operand_serializer (
   input  logic          clk,
   input  logic          i_rst,
   input  logic          i_start_ok,
   input  logic          i_pc_en,
   input  pc_pkg::word_t i_imm_word,
   input  pc_pkg::word_t i_offset_word,
   input  pc_pkg::word_t i_csr_word,
   output logic          o_imm,
   output logic          o_buf,
   output logic          o_csr_pc
);

   pc_pkg::word_t imm_sr;
   pc_pkg::word_t offset_sr;
   pc_pkg::word_t csr_sr;

   //////////////////////////////////////////////////
   // Load on start, then one bit per bit time
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (i_rst) begin
         imm_sr    <= '0;
         offset_sr <= '0;
         csr_sr    <= '0;
      end else if (i_start_ok) begin
         imm_sr    <= i_imm_word;
         offset_sr <= i_offset_word;
         csr_sr    <= i_csr_word;
      end else if (i_pc_en) begin
         imm_sr    <= imm_sr >> 1;
         offset_sr <= offset_sr >> 1;
         csr_sr    <= csr_sr >> 1;
      end
   end

   // Bit k sits in position 0 during bit time k.
   assign o_imm    = imm_sr[0];
   assign o_buf    = offset_sr[0];
   assign o_csr_pc = csr_sr[0];

endmodule

/* logic/bit_counter.sv */
module bit_counter (
   input  logic             clk,
   input  logic             i_rst,
   input  logic             i_start,
   input  logic             i_ibus_cyc,
   output logic             o_start_ok,
   output logic             o_pc_en,
   output pc_pkg::cnt_hi_t  o_cnt,
   output pc_pkg::cnt_lsb_t o_cnt_r,
   output logic             o_cnt_done,
   output logic             o_done
);

   pc_pkg::count_state_t state;

   // No new operation while a fetch is still outstanding.
   assign o_start_ok = i_start & (state == pc_pkg::idle) & ~i_ibus_cyc;
   assign o_pc_en    = (state == pc_pkg::run);
   assign o_cnt_done = o_pc_en & o_cnt_r[3] & (o_cnt == 3'd7);   // Bit time 31.

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state   <= pc_pkg::idle;
         o_cnt   <= '0;
         o_cnt_r <= 4'b0001;
         o_done  <= 1'b0;
      end else begin
         o_done <= o_cnt_done;
         case (state)
            pc_pkg::idle: begin
               if (o_start_ok) begin
                  state   <= pc_pkg::run;
                  o_cnt   <= '0;
                  o_cnt_r <= 4'b0001;
               end
            end
            pc_pkg::run: begin
               o_cnt_r <= {o_cnt_r[2:0], o_cnt_r[3]};
               if (o_cnt_r[3]) begin
                  o_cnt <= o_cnt + 3'd1;             // Wraps back to zero after bit 31.
               end
               if (o_cnt_done) begin
                  state <= pc_pkg::idle;
               end
            end
            default: begin
               state <= pc_pkg::idle;
            end
         endcase
      end
   end

endmodule

/* logic/shift_reg.sv */
module shift_reg #(
   parameter int             LEN  = 32,
   parameter logic [LEN-1:0] INIT = '0
) (
   input  logic           clk,
   input  logic           i_rst,
   input  logic           i_en,
   input  logic           i_d,
   output logic           o_q,
   output logic [LEN-1:1] o_par
);

   logic [LEN-1:0] data;

   // LSB leaves first, the new bit enters at the top.
   always_ff @(posedge clk) begin
      if (i_rst) begin
         data <= INIT;
      end else if (i_en) begin
         data <= {i_d, data[LEN-1:1]};
      end
   end

   assign o_q   = data[0];
   assign o_par = data[LEN-1:1];

endmodule

/* logic/pc_pkg.sv */
`include "pc_settings.svh"

package pc_pkg;

   typedef logic [`PC_WORD_BITS-1:0] word_t;    // PC, operand or result word.

   typedef logic [2:0] cnt_hi_t;                // Bit time divided by four.

   typedef logic [3:0] cnt_lsb_t;               // One-hot position inside a nibble.

   typedef enum logic {
      idle,
      run
   } count_state_t;

endpackage

/* logic/pc_settings.svh */
`ifndef PC_SETTINGS_SVH
`define PC_SETTINGS_SVH

// Width of the PC and of every operand and result word.
`define PC_WORD_BITS 32

// First fetch address after reset.
`define PC_RESET_ADDR 32'h0000_0100

// Set to 0 to drop the trap path from the next-PC select.
`define PC_WITH_CSR 1

`endif
